// File: logic/arch_defs_pkg.sv
package arch_defs_pkg;

    // Data bus and register width
    localparam int DATA_WIDTH = 8;
    // Address bus width
    localparam int ADDR_WIDTH = 16;

    // Program counter value after reset
    localparam logic [ADDR_WIDTH-1:0] RESET_VECTOR = 16'h0000;

    // Status register layout
    localparam int FLAG_COUNT = 3;
    localparam int FLAG_Z = 0;
    localparam int FLAG_C = 1;
    localparam int FLAG_N = 2;

    // Instruction set
    // Address operands come high byte first
    typedef enum logic [DATA_WIDTH-1:0] {
        NOP    = 8'h00,
        LDI_A  = 8'h01,
        LDA    = 8'h02,
        STA    = 8'h03,
        MOV_AB = 8'h04,
        ADD    = 8'h10,
        SUB    = 8'h11,
        AND_AB = 8'h12,
        OR_AB  = 8'h13,
        JMP    = 8'h20,
        JZ     = 8'h21,
        JC     = 8'h22,
        JN     = 8'h23,
        OUTA   = 8'h30,
        HLT    = 8'hff
    } opcode_t;

endpackage

// File: logic/micro_defs_pkg.sv
package micro_defs_pkg;

    // Longest instruction takes this many steps
    localparam int MICRO_STEPS = 8;

    // ALU function select
    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR
    } alu_op_t;

    // Microstep counter states
    // T0 and T1 are always the fetch
    typedef enum logic [$clog2(MICRO_STEPS)-1:0] {
        T0,
        T1,
        T2,
        T3,
        T4,
        T5,
        T6,
        T7
    } micro_step_t;

endpackage

// File: logic/control_unit.sv
`timescale 1ns/1ps

module control_unit
    import arch_defs_pkg::*;
    import micro_defs_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  opcode_t               opcode_i,
    input  logic [FLAG_COUNT-1:0] flags_i,
    // Internal bus sources
    output logic                  oe_ram_o,
    output logic                  oe_alu_o,
    output logic                  oe_a_o,
    output logic                  oe_b_o,
    output logic                  oe_tmp_o,
    // Register loads
    output logic                  load_a_o,
    output logic                  load_b_o,
    output logic                  load_tmp_o,
    output logic                  load_ir_o,
    output logic                  load_flags_o,
    output logic                  load_sets_zn_o,
    // Program counter and memory address register
    output logic                  pc_enable_o,
    output logic                  load_pc_high_o,
    output logic                  load_pc_low_o,
    output logic                  load_mar_pc_o,
    output logic                  load_mar_high_o,
    output logic                  load_mar_low_o,
    // Memory and output port
    output logic                  mem_write_o,
    output logic                  out_load_o,
    output logic                  halt_o,
    output alu_op_t               alu_op_o
);

    micro_step_t step;
    logic        last_step;
    logic        taken;

    // Branch condition
    // Flags are tested here and nowhere else
    always_comb begin
        unique case (opcode_i)
            JMP:     taken = 1'b1;
            JZ:      taken = flags_i[FLAG_Z];
            JC:      taken = flags_i[FLAG_C];
            JN:      taken = flags_i[FLAG_N];
            default: taken = 1'b0;
        endcase
    end

    // Step counter
    // Holds while halted so HLT stays decoded until reset
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            step <= T0;
        end else if (last_step) begin
            step <= T0;
        end else if (!halt_o) begin
            step <= micro_step_t'(step + 3'd1);
        end
    end

    // ========================================================================
    // Microcode table
    // ========================================================================
    always_comb begin
        // Idle unless a step asks for it
        oe_ram_o        = 1'b0;
        oe_alu_o        = 1'b0;
        oe_a_o          = 1'b0;
        oe_b_o          = 1'b0;
        oe_tmp_o        = 1'b0;
        load_a_o        = 1'b0;
        load_b_o        = 1'b0;
        load_tmp_o      = 1'b0;
        load_ir_o       = 1'b0;
        load_flags_o    = 1'b0;
        load_sets_zn_o  = 1'b0;
        pc_enable_o     = 1'b0;
        load_pc_high_o  = 1'b0;
        load_pc_low_o   = 1'b0;
        load_mar_pc_o   = 1'b0;
        load_mar_high_o = 1'b0;
        load_mar_low_o  = 1'b0;
        mem_write_o     = 1'b0;
        out_load_o      = 1'b0;
        halt_o          = 1'b0;
        alu_op_o        = ALU_ADD;
        last_step       = 1'b0;

        if (step == T0) begin
            // Point memory at the next instruction
            load_mar_pc_o = 1'b1;
        end else if (step == T1) begin
            // Opcode into IR and step past it
            oe_ram_o    = 1'b1;
            load_ir_o   = 1'b1;
            pc_enable_o = 1'b1;
        end else begin
            case (opcode_i)
                LDI_A: begin
                    case (step)
                        T2: load_mar_pc_o = 1'b1;
                        T3: begin
                            oe_ram_o    = 1'b1;
                            load_tmp_o  = 1'b1;
                            pc_enable_o = 1'b1;
                        end
                        default: begin
                            // Immediate from TMP into A with Z and N
                            oe_tmp_o       = 1'b1;
                            load_a_o       = 1'b1;
                            load_flags_o   = 1'b1;
                            load_sets_zn_o = 1'b1;
                            last_step      = 1'b1;
                        end
                    endcase
                end
                LDA, STA: begin
                    case (step)
                        T2, T4: load_mar_pc_o = 1'b1;
                        T3: begin
                            // High address byte parked in TMP
                            oe_ram_o    = 1'b1;
                            load_tmp_o  = 1'b1;
                            pc_enable_o = 1'b1;
                        end
                        T5: begin
                            oe_ram_o       = 1'b1;
                            load_mar_low_o = 1'b1;
                            pc_enable_o    = 1'b1;
                        end
                        T6: begin
                            oe_tmp_o        = 1'b1;
                            load_mar_high_o = 1'b1;
                        end
                        default: begin
                            if (opcode_i == LDA) begin
                                oe_ram_o       = 1'b1;
                                load_a_o       = 1'b1;
                                load_flags_o   = 1'b1;
                                load_sets_zn_o = 1'b1;
                            end else begin
                                mem_write_o = 1'b1;
                            end
                            last_step = 1'b1;
                        end
                    endcase
                end
                ADD, SUB, AND_AB, OR_AB: begin
                    case (opcode_i)
                        SUB:     alu_op_o = ALU_SUB;
                        AND_AB:  alu_op_o = ALU_AND;
                        OR_AB:   alu_op_o = ALU_OR;
                        default: alu_op_o = ALU_ADD;
                    endcase
                    // T2 only lets the ALU latch
                    if (step == T3) begin
                        oe_alu_o     = 1'b1;
                        load_a_o     = 1'b1;
                        load_flags_o = 1'b1;
                        last_step    = 1'b1;
                    end
                end
                JMP, JZ, JC, JN: begin
                    case (step)
                        T2, T4: load_mar_pc_o = 1'b1;
                        T3: begin
                            oe_ram_o    = 1'b1;
                            load_tmp_o  = 1'b1;
                            pc_enable_o = 1'b1;
                        end
                        T5: begin
                            // MAR already holds the low byte address
                            if (taken) begin
                                oe_tmp_o       = 1'b1;
                                load_pc_high_o = 1'b1;
                            end
                        end
                        default: begin
                            if (taken) begin
                                oe_ram_o      = 1'b1;
                                load_pc_low_o = 1'b1;
                            end else begin
                                pc_enable_o = 1'b1;
                            end
                            last_step = 1'b1;
                        end
                    endcase
                end
                MOV_AB: begin
                    oe_a_o    = 1'b1;
                    load_b_o  = 1'b1;
                    last_step = 1'b1;
                end
                OUTA: begin
                    out_load_o = 1'b1;
                    last_step  = 1'b1;
                end
                HLT: halt_o = 1'b1;
                // NOP and unknown codes
                default: last_step = 1'b1;
            endcase
        end
    end

endmodule

// File: logic/alu.sv
`timescale 1ns/1ps

module alu
    import arch_defs_pkg::*;
    import micro_defs_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic [DATA_WIDTH-1:0] a_i,
    input  logic [DATA_WIDTH-1:0] b_i,
    input  alu_op_t               alu_op_i,
    output logic [DATA_WIDTH-1:0] result_o,
    output logic                  zero_o,
    output logic                  carry_o,
    output logic                  negative_o
);

    // Extra top bit holds carry or borrow
    logic [DATA_WIDTH:0] wide;

    always_comb begin
        unique case (alu_op_i)
            ALU_ADD: wide = {1'b0, a_i} + {1'b0, b_i};
            // Top bit set when B exceeds A
            ALU_SUB: wide = {1'b0, a_i} - {1'b0, b_i};
            ALU_AND: wide = {1'b0, a_i & b_i};
            ALU_OR:  wide = {1'b0, a_i | b_i};
            default: wide = '0;
        endcase
    end

    // Result and flags latched every edge
    // Z and N follow the byte being registered
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            result_o   <= '0;
            zero_o     <= 1'b0;
            carry_o    <= 1'b0;
            negative_o <= 1'b0;
        end else begin
            result_o   <= wide[DATA_WIDTH-1:0];
            zero_o     <= (wide[DATA_WIDTH-1:0] == '0);
            carry_o    <= wide[DATA_WIDTH];
            negative_o <= wide[DATA_WIDTH-1];
        end
    end

endmodule

// File: logic/datapath.sv
`timescale 1ns/1ps

module datapath
    import arch_defs_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n_i,
    // Internal bus sources
    input  logic                  oe_ram_i,
    input  logic                  oe_alu_i,
    input  logic                  oe_a_i,
    input  logic                  oe_b_i,
    input  logic                  oe_tmp_i,
    // Register loads
    input  logic                  load_a_i,
    input  logic                  load_b_i,
    input  logic                  load_tmp_i,
    input  logic                  load_ir_i,
    input  logic                  load_flags_i,
    input  logic                  load_sets_zn_i,
    // Program counter and memory address register
    input  logic                  pc_enable_i,
    input  logic                  load_pc_high_i,
    input  logic                  load_pc_low_i,
    input  logic                  load_mar_pc_i,
    input  logic                  load_mar_high_i,
    input  logic                  load_mar_low_i,
    // Incoming data
    input  logic [DATA_WIDTH-1:0] mem_data_i,
    input  logic [DATA_WIDTH-1:0] alu_result_i,
    input  logic                  alu_zero_i,
    input  logic                  alu_carry_i,
    input  logic                  alu_negative_i,
    output logic [ADDR_WIDTH-1:0] mem_address_o,
    output logic [DATA_WIDTH-1:0] a_o,
    output logic [DATA_WIDTH-1:0] b_o,
    output opcode_t               opcode_o,
    output logic [FLAG_COUNT-1:0] flags_o,
    output logic [ADDR_WIDTH-1:0] pc_o
);

    logic [DATA_WIDTH-1:0] bus;
    logic [DATA_WIDTH-1:0] tmp;
    logic [DATA_WIDTH-1:0] ir;
    logic [FLAG_COUNT-1:0] flags_next;

    // ========================================================================
    // Internal bus
    // ========================================================================
    // Priority mux in place of tri-states
    // Idle bus reads as zero
    always_comb begin
        if (oe_ram_i) begin
            bus = mem_data_i;
        end else if (oe_alu_i) begin
            bus = alu_result_i;
        end else if (oe_a_i) begin
            bus = a_o;
        end else if (oe_b_i) begin
            bus = b_o;
        end else if (oe_tmp_i) begin
            bus = tmp;
        end else begin
            bus = '0;
        end
    end

    // ========================================================================
    // Byte registers
    // ========================================================================
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            a_o <= '0;
            b_o <= '0;
            tmp <= '0;
            ir  <= '0;
        end else begin
            if (load_a_i) a_o <= bus;
            if (load_b_i) b_o <= bus;
            // Scratch for immediates and address high bytes
            if (load_tmp_i) tmp <= bus;
            if (load_ir_i) ir <= bus;
        end
    end

    // Unlisted codes pass through and decode as NOP
    assign opcode_o = opcode_t'(ir);

    // Program counter
    // Byte loads for jumps and increment for sequential fetch
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_o <= RESET_VECTOR;
        end else if (load_pc_high_i) begin
            pc_o[ADDR_WIDTH-1:DATA_WIDTH] <= bus;
        end else if (load_pc_low_i) begin
            pc_o[DATA_WIDTH-1:0] <= bus;
        end else if (pc_enable_i) begin
            pc_o <= pc_o + ADDR_WIDTH'(1);
        end
    end

    // Memory address register drives the address bus directly
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mem_address_o <= '0;
        end else if (load_mar_pc_i) begin
            mem_address_o <= pc_o;
        end else if (load_mar_high_i) begin
            mem_address_o[ADDR_WIDTH-1:DATA_WIDTH] <= bus;
        end else if (load_mar_low_i) begin
            mem_address_o[DATA_WIDTH-1:0] <= bus;
        end
    end

    // ========================================================================
    // Status flags
    // ========================================================================
    always_comb begin
        if (load_sets_zn_i) begin
            // Loads judge the byte on the bus and clear carry
            flags_next[FLAG_Z] = (bus == '0);
            flags_next[FLAG_C] = 1'b0;
            flags_next[FLAG_N] = bus[DATA_WIDTH-1];
        end else begin
            flags_next[FLAG_Z] = alu_zero_i;
            flags_next[FLAG_C] = alu_carry_i;
            flags_next[FLAG_N] = alu_negative_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            flags_o <= '0;
        end else if (load_flags_i) begin
            flags_o <= flags_next;
        end
    end

endmodule

// File: logic/cpu.sv
`timescale 1ns/1ps

module cpu
    import arch_defs_pkg::*;
    import micro_defs_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n_i,
    // Memory bus
    input  logic [DATA_WIDTH-1:0] mem_data_i,
    output logic [ADDR_WIDTH-1:0] mem_address_o,
    output logic                  mem_read_o,
    output logic                  mem_write_o,
    output logic [DATA_WIDTH-1:0] mem_data_o,
    // Output port
    output logic                  out_load_o,
    output logic [DATA_WIDTH-1:0] out_data_o,
    // Status
    output logic                  halt_o,
    output logic                  flag_zero_o,
    output logic                  flag_carry_o,
    output logic                  flag_negative_o,
    // Debug taps
    output logic [ADDR_WIDTH-1:0] debug_pc_o,
    output logic [DATA_WIDTH-1:0] debug_ir_o
);

    // Control strobes
    logic oe_ram, oe_alu, oe_a, oe_b, oe_tmp;
    logic load_a, load_b, load_tmp, load_ir, load_flags, load_sets_zn;
    logic pc_enable, load_pc_high, load_pc_low;
    logic load_mar_pc, load_mar_high, load_mar_low;
    alu_op_t alu_op;

    // Datapath and ALU state
    opcode_t               opcode;
    logic [FLAG_COUNT-1:0] flags;
    logic [DATA_WIDTH-1:0] a;
    logic [DATA_WIDTH-1:0] b;
    logic [DATA_WIDTH-1:0] alu_result;
    logic                  alu_zero, alu_carry, alu_negative;

    // ========================================================================
    // External connections
    // ========================================================================
    // Memory reads whenever RAM drives the bus
    assign mem_read_o      = oe_ram;
    // Stores and the output port both take A
    assign mem_data_o      = a;
    assign out_data_o      = a;
    assign flag_zero_o     = flags[FLAG_Z];
    assign flag_carry_o    = flags[FLAG_C];
    assign flag_negative_o = flags[FLAG_N];
    assign debug_ir_o      = opcode;

    control_unit u_control_unit (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .opcode_i        (opcode),
        .flags_i         (flags),
        .oe_ram_o        (oe_ram),
        .oe_alu_o        (oe_alu),
        .oe_a_o          (oe_a),
        .oe_b_o          (oe_b),
        .oe_tmp_o        (oe_tmp),
        .load_a_o        (load_a),
        .load_b_o        (load_b),
        .load_tmp_o      (load_tmp),
        .load_ir_o       (load_ir),
        .load_flags_o    (load_flags),
        .load_sets_zn_o  (load_sets_zn),
        .pc_enable_o     (pc_enable),
        .load_pc_high_o  (load_pc_high),
        .load_pc_low_o   (load_pc_low),
        .load_mar_pc_o   (load_mar_pc),
        .load_mar_high_o (load_mar_high),
        .load_mar_low_o  (load_mar_low),
        .mem_write_o     (mem_write_o),
        .out_load_o      (out_load_o),
        .halt_o          (halt_o),
        .alu_op_o        (alu_op)
    );

    alu u_alu (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .a_i        (a),
        .b_i        (b),
        .alu_op_i   (alu_op),
        .result_o   (alu_result),
        .zero_o     (alu_zero),
        .carry_o    (alu_carry),
        .negative_o (alu_negative)
    );

    datapath u_datapath (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .oe_ram_i        (oe_ram),
        .oe_alu_i        (oe_alu),
        .oe_a_i          (oe_a),
        .oe_b_i          (oe_b),
        .oe_tmp_i        (oe_tmp),
        .load_a_i        (load_a),
        .load_b_i        (load_b),
        .load_tmp_i      (load_tmp),
        .load_ir_i       (load_ir),
        .load_flags_i    (load_flags),
        .load_sets_zn_i  (load_sets_zn),
        .pc_enable_i     (pc_enable),
        .load_pc_high_i  (load_pc_high),
        .load_pc_low_i   (load_pc_low),
        .load_mar_pc_i   (load_mar_pc),
        .load_mar_high_i (load_mar_high),
        .load_mar_low_i  (load_mar_low),
        .mem_data_i      (mem_data_i),
        .alu_result_i    (alu_result),
        .alu_zero_i      (alu_zero),
        .alu_carry_i     (alu_carry),
        .alu_negative_i  (alu_negative),
        .mem_address_o   (mem_address_o),
        .a_o             (a),
        .b_o             (b),
        .opcode_o        (opcode),
        .flags_o         (flags),
        .pc_o            (debug_pc_o)
    );

endmodule

// File: bench/cpu_asserts.sv
`timescale 1ns/1ps

module cpu_asserts (
    input logic clk,
    input logic rst_n_i,
    input logic mem_read_i,
    input logic mem_write_i,
    input logic out_load_i,
    input logic halt_i
);

    // Memory is either read or written, never both
    a_read_write_exclusive : assert property (
        @(posedge clk) disable iff (!rst_n_i) !(mem_read_i && mem_write_i)
    ) else $error("mem_read_o and mem_write_o high in the same cycle");

    // First cycle after reset is quiet
    a_quiet_after_reset : assert property (
        @(posedge clk) $rose(rst_n_i) |-> !mem_read_i && !mem_write_i && !out_load_i && !halt_i
    ) else $error("strobe active in the first cycle after reset");

    // HLT holds until reset
    a_halt_sticky : assert property (
        @(posedge clk) disable iff (!rst_n_i) halt_i |=> halt_i
    ) else $error("halt_o dropped without a reset");

endmodule

bind cpu cpu_asserts cpu_asserts_inst (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .mem_read_i  (mem_read_o),
    .mem_write_i (mem_write_o),
    .out_load_i  (out_load_o),
    .halt_i      (halt_o)
);

// File: bench/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb
    import arch_defs_pkg::*;
();

    localparam string STIM_FILE = "bench/program_stim.txt";
    localparam int    MEM_BYTES = 1 << ADDR_WIDTH;

    logic                  clk;
    logic                  rst_n_i;
    logic [DATA_WIDTH-1:0] mem_data_i;
    logic [ADDR_WIDTH-1:0] mem_address_o;
    logic                  mem_read_o;
    logic                  mem_write_o;
    logic [DATA_WIDTH-1:0] mem_data_o;
    logic                  out_load_o;
    logic [DATA_WIDTH-1:0] out_data_o;
    logic                  halt_o;
    logic                  flag_zero_o;
    logic                  flag_carry_o;
    logic                  flag_negative_o;
    logic [ADDR_WIDTH-1:0] debug_pc_o;
    logic [DATA_WIDTH-1:0] debug_ir_o;

    // Program image, expected port bytes, expected stores and final flags
    logic [DATA_WIDTH-1:0] mem [0:MEM_BYTES-1];
    logic [ADDR_WIDTH-1:0] prog_addr_q[$];
    logic [DATA_WIDTH-1:0] prog_data_q[$];
    logic [DATA_WIDTH-1:0] exp_out_q[$];
    logic [ADDR_WIDTH-1:0] wr_addr_q[$];
    logic [DATA_WIDTH-1:0] wr_data_q[$];
    logic [FLAG_COUNT-1:0] exp_flags;
    logic [FLAG_COUNT-1:0] got_flags;
    logic                  stim_loaded = 1'b0;
    // Opcode seen at the previous sample and sticky halt seen
    logic [DATA_WIDTH-1:0] last_ir = '0;
    logic                  halted = 1'b0;

    cpu cpu_inst (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .mem_data_i      (mem_data_i),
        .mem_address_o   (mem_address_o),
        .mem_read_o      (mem_read_o),
        .mem_write_o     (mem_write_o),
        .mem_data_o      (mem_data_o),
        .out_load_o      (out_load_o),
        .out_data_o      (out_data_o),
        .halt_o          (halt_o),
        .flag_zero_o     (flag_zero_o),
        .flag_carry_o    (flag_carry_o),
        .flag_negative_o (flag_negative_o),
        .debug_pc_o      (debug_pc_o),
        .debug_ir_o      (debug_ir_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ========================================================================
    // Reporting and compare tasks
    // ========================================================================
    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: %s is 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_addr(input string name, input logic [ADDR_WIDTH-1:0] got,
                                input logic [ADDR_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("** Error: %s is 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_out(input logic [DATA_WIDTH-1:0] got,
                             input logic [DATA_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("** Error: out_data_o is 0x%h, expected 0x%h", got, exp);
            abort_run();
        end
    endtask

    // Fetched opcode against the byte in memory
    task automatic check_ir(input logic [DATA_WIDTH-1:0] got,
                            input logic [DATA_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("** Error: debug_ir_o is 0x%h, expected 0x%h", got, exp);
            abort_run();
        end
    endtask

    // Bit 0 Z, bit 1 C, bit 2 N
    task automatic check_flags(input logic [FLAG_COUNT-1:0] got,
                               input logic [FLAG_COUNT-1:0] exp);
        if (got !== exp) begin
            $display("** Error: flags (N,C,Z) is 0x%h, expected 0x%h", got, exp);
            abort_run();
        end
    endtask

    task automatic check_mem(input logic [ADDR_WIDTH-1:0] addr,
                             input logic [DATA_WIDTH-1:0] exp);
        if (mem[addr] !== exp) begin
            $display("** Error: mem[0x%h] is 0x%h, expected 0x%h", addr, mem[addr], exp);
            abort_run();
        end
    endtask

    // ========================================================================
    // Stimulus file
    // ========================================================================
    task automatic load_stimulus();
        int                    fd;
        int                    code;
        int                    ch;
        int                    count;
        logic                  done;
        logic [7:0]            tag;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] value;
        logic                  z;
        logic                  c;
        logic                  n;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file %s", STIM_FILE);
            abort_run();
        end
        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, " %c", tag);
            if (code != 1) begin
                done = 1'b1;
            end else begin
                case (tag)
                    "#": begin
                        // Skip the rest of a comment line
                        ch = $fgetc(fd);
                        while (ch != 10 && ch != -1) ch = $fgetc(fd);
                    end
                    "M": begin
                        code = $fscanf(fd, "%h %d", addr, count);
                        repeat (count) begin
                            code = $fscanf(fd, "%h", value);
                            prog_addr_q.push_back(addr);
                            prog_data_q.push_back(value);
                            addr = addr + 16'd1;
                        end
                    end
                    "O": begin
                        code = $fscanf(fd, "%h", value);
                        exp_out_q.push_back(value);
                    end
                    "W": begin
                        code = $fscanf(fd, "%h %h", addr, value);
                        wr_addr_q.push_back(addr);
                        wr_data_q.push_back(value);
                    end
                    "F": begin
                        code = $fscanf(fd, "%b %b %b", z, c, n);
                        exp_flags[FLAG_Z] = z;
                        exp_flags[FLAG_C] = c;
                        exp_flags[FLAG_N] = n;
                    end
                    default: begin
                        $display("Unknown tag %c in the stimulus file", tag);
                        abort_run();
                    end
                endcase
            end
        end
        $fclose(fd);
    endtask

    // ========================================================================
    // Memory model
    // ========================================================================
    // Asynchronous read while the CPU reads
    assign mem_data_i = mem_read_o ? mem[mem_address_o] : '0;

    initial begin : memory_model
        int idx;
        wait (stim_loaded);
        for (idx = 0; idx < MEM_BYTES; idx++) begin
            mem[ADDR_WIDTH'(idx)] <= '0;
        end
        for (idx = 0; idx < prog_addr_q.size(); idx++) begin
            mem[prog_addr_q[idx]] <= prog_data_q[idx];
        end
        // Stores land on the rising edge
        forever begin
            @(posedge clk);
            if (mem_write_o) mem[mem_address_o] <= mem_data_o;
        end
    end

    // Output port, fetches and post-halt activity, sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n_i) begin
            if (halted && (out_load_o || mem_write_o)) begin
                $display("Strobe activity after HLT (out_load_o=%b mem_write_o=%b)",
                         out_load_o, mem_write_o);
                abort_run();
            end else if (out_load_o) begin
                if (exp_out_q.size() == 0) begin
                    $display("Output pulse with 0x%h when no more output was expected",
                             out_data_o);
                    abort_run();
                end else begin
                    check_out(out_data_o, exp_out_q.pop_front());
                end
            end
            // A new opcode is the byte just behind the program counter
            if (debug_ir_o !== last_ir) begin
                check_ir(debug_ir_o, mem[debug_pc_o - 16'd1]);
            end
            last_ir = debug_ir_o;
            if (halt_o) begin
                halted = 1'b1;
            end
        end
    end

    // Budget of 8 cycles per program byte plus 100
    initial begin : watchdog
        int limit;
        wait (stim_loaded);
        limit = prog_data_q.size() * 8 + 100;
        repeat (limit) @(posedge clk);
        $display("Timeout: the CPU never halted within %0d cycles", limit);
        abort_run();
    end

    // ========================================================================
    // Main sequence
    // ========================================================================
    initial begin
        rst_n_i = 1'b0;
        load_stimulus();
        stim_loaded = 1'b1;
        repeat (3) @(posedge clk);
        rst_n_i <= 1'b1;

        // First cycle out of reset
        @(negedge clk);
        compare_bit("halt_o", halt_o, 1'b0);
        compare_bit("out_load_o", out_load_o, 1'b0);
        compare_bit("mem_read_o", mem_read_o, 1'b0);
        compare_bit("mem_write_o", mem_write_o, 1'b0);
        compare_addr("debug_pc_o", debug_pc_o, RESET_VECTOR);
        check_ir(debug_ir_o, 8'h00);

        while (!halt_o) @(negedge clk);

        // Halt must hold with the port quiet
        repeat (8) begin
            @(negedge clk);
            compare_bit("halt_o", halt_o, 1'b1);
        end

        got_flags[FLAG_Z] = flag_zero_o;
        got_flags[FLAG_C] = flag_carry_o;
        got_flags[FLAG_N] = flag_negative_o;
        check_flags(got_flags, exp_flags);
        foreach (wr_addr_q[i]) begin
            check_mem(wr_addr_q[i], wr_data_q[i]);
        end

        if (exp_out_q.size() != 0) begin
            $display("Program halted with %0d expected outputs missing", exp_out_q.size());
            abort_run();
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

// File: bench/program_stim.txt
# M: start address, byte count, program bytes (hex)  W: address, stored byte (hex)
# O: expected output byte (hex), in order  F: final Z C N flags
M 0000 8 01 80 30 04 01 90 10 30
M 0008 8 04 01 05 11 30 04 01 3c
M 0010 8 12 30 04 01 41 13 30 01
M 0018 8 a5 03 12 34 01 00 02 12
M 0020 8 34 30 21 00 80 23 00 40
M 0028 4 01 ee 30 ff
M 0040 8 01 00 30 22 00 60 21 00
M 0048 5 50 01 dd 30 ff
M 0050 8 01 ff 04 01 02 10 23 00
M 0058 8 70 22 00 60 01 cc 30 ff
M 0060 4 30 11 30 ff
W 1234 a5
O 80
O 10
O f5
O 34
O 75
O a5
O 00
O 01
O 02
F 0 1 0

// File: vlog.f
logic/arch_defs_pkg.sv
logic/micro_defs_pkg.sv
logic/control_unit.sv
logic/alu.sv
logic/datapath.sv
logic/cpu.sv
bench/cpu_asserts.sv
bench/cpu_tb.sv

// File: Makefile
TOP = cpu_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f vlog.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vlog.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir
